/* Bender.yml */
package:
  name: axi_csr

sources:
  - rtl/axi_lite_pkg.sv
  - rtl/conv_csr_pkg.sv
  - rtl/csr_axi_ctrl.sv
  - rtl/csr_reg_file.sv
  - rtl/csr_read_mux.sv
  - rtl/axi_csr_top.sv
  - target: test
    files:
      - test/tb_axi_csr.sv

/* build.f */
rtl/axi_lite_pkg.sv
rtl/conv_csr_pkg.sv
rtl/csr_axi_ctrl.sv
rtl/csr_reg_file.sv
rtl/csr_read_mux.sv
rtl/axi_csr_top.sv
test/tb_axi_csr.sv

/* rtl/axi_csr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_csr_top (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// ----------------------------------------
	// AXI4-Lite slave port
	input wire axi_lite_pkg::axi_addr_t S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input wire axi_lite_pkg::axi_data_t S_AXI_WDATA,
	input wire axi_lite_pkg::axi_strb_t S_AXI_WSTRB,
	input wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output axi_lite_pkg::axi_resp_t S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input wire S_AXI_BREADY,
	input wire axi_lite_pkg::axi_addr_t S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output axi_lite_pkg::axi_data_t S_AXI_RDATA,
	output axi_lite_pkg::axi_resp_t S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input wire S_AXI_RREADY,
	// ----------------------------------------
	// Engine status in
	input wire running,
	input wire compute_done,
	input wire exception,
	// ----------------------------------------
	// Engine configuration out
	output conv_csr_pkg::conv_param_t kernel_size,
	output conv_csr_pkg::conv_param_t stride,
	output conv_csr_pkg::conv_param_t padding,
	output logic has_bias,
	output logic has_relu,
	output logic conv_mode,
	output logic start,
	output conv_csr_pkg::csr_word_t kernel_baseaddr,
	output conv_csr_pkg::csr_word_t feature_baseaddr,
	output conv_csr_pkg::csr_word_t feature_width,
	output conv_csr_pkg::csr_word_t feature_height,
	output conv_csr_pkg::csr_word_t feature_chin,
	output conv_csr_pkg::csr_word_t feature_chout,
	output conv_csr_pkg::csr_word_t output_baseaddr,
	output conv_csr_pkg::csr_word_t output_width,
	output conv_csr_pkg::csr_word_t output_height
);
	import conv_csr_pkg::*;

	// Controller to register file
	logic wr_commit;
	reg_idx_t wr_idx;
	// Controller to read mux
	logic rd_capture;

	// Handshakes, commit and capture strobes
	csr_axi_ctrl u_ctrl (.*);

	// Register storage and start pulse
	csr_reg_file u_regs (.*);

	// Read index and data select
	csr_read_mux u_rmux (.*);

endmodule

`default_nettype wire

/* rtl/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------

	// Six address bits cover sixteen words
	localparam int axi_addr_w = 6;
	localparam int axi_data_w = 32;
	// One strobe per byte lane
	localparam int axi_strb_w = axi_data_w / 8;

	typedef logic [axi_addr_w-1:0] axi_addr_t;
	typedef logic [axi_data_w-1:0] axi_data_t;
	typedef logic [axi_strb_w-1:0] axi_strb_t;

	// ----------------------------------------
	// Responses and channel states
	// ----------------------------------------

	typedef logic [1:0] axi_resp_t;

	// Only OKAY is ever returned
	localparam axi_resp_t resp_okay = 2'b00;

	// Idle right after reset, then address wait, then data or response
	typedef enum logic [1:0] {
		ch_idle,
		ch_addr,
		ch_data
	} chan_state_e;

endpackage

`default_nettype wire

/* rtl/conv_csr_pkg.sv */
`default_nettype none

package conv_csr_pkg;

	// ----------------------------------------
	// Register map
	// ----------------------------------------

	// Word index taken from address bits 5:2
	localparam int reg_idx_w = 4;
	localparam int addr_lsb = 2;

	typedef logic [reg_idx_w-1:0] reg_idx_t;

	localparam reg_idx_t reg_ctrl = reg_idx_t'(0);
	localparam reg_idx_t reg_kernel_base = reg_idx_t'(1);
	localparam reg_idx_t reg_feature_base = reg_idx_t'(2);
	localparam reg_idx_t reg_feature_width = reg_idx_t'(3);
	localparam reg_idx_t reg_feature_height = reg_idx_t'(4);
	localparam reg_idx_t reg_feature_chin = reg_idx_t'(5);
	localparam reg_idx_t reg_feature_chout = reg_idx_t'(6);
	localparam reg_idx_t reg_output_base = reg_idx_t'(7);
	localparam reg_idx_t reg_output_width = reg_idx_t'(8);
	localparam reg_idx_t reg_output_height = reg_idx_t'(9);

	// Indexes 10 to 15 are unmapped
	localparam int reg_count = 10;

	// ----------------------------------------
	// Control word layout
	// ----------------------------------------

	// Self-clearing start request
	localparam int ctrl_start_bit = 0;
	// Status bits 1 to 3 are read only
	localparam int ctrl_exception_bit = 1;
	localparam int ctrl_done_bit = 2;
	localparam int ctrl_running_bit = 3;
	// Bit 4 is reserved and reads zero
	localparam int ctrl_conv_mode_bit = 5;
	localparam int ctrl_relu_bit = 6;
	localparam int ctrl_bias_bit = 7;
	// Byte-wide convolution parameters
	localparam int ctrl_padding_lsb = 8;
	localparam int ctrl_stride_lsb = 16;
	localparam int ctrl_kernel_lsb = 24;

	// Kernel size, stride and padding
	typedef logic [7:0] conv_param_t;
	// Base addresses, dimensions and channel counts
	typedef logic [31:0] csr_word_t;

endpackage

`default_nettype wire

/* rtl/csr_axi_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_axi_ctrl (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Write address and data channels
	input wire axi_lite_pkg::axi_addr_t S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	// Write response channel
	output logic S_AXI_BVALID,
	output axi_lite_pkg::axi_resp_t S_AXI_BRESP,
	input wire S_AXI_BREADY,
	// Read address and data channels
	input wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output logic S_AXI_RVALID,
	output axi_lite_pkg::axi_resp_t S_AXI_RRESP,
	input wire S_AXI_RREADY,
	// Engine busy, locks out register writes
	input wire running,
	// Strobes toward the register file and read mux
	output logic wr_commit,
	output conv_csr_pkg::reg_idx_t wr_idx,
	output logic rd_capture
);
	import axi_lite_pkg::*;
	import conv_csr_pkg::*;

	chan_state_e wr_state;
	chan_state_e rd_state;
	// Address taken, data still outstanding
	logic aw_held;
	reg_idx_t wr_idx_q;
	logic aw_fire;
	logic w_fire;
	logic ar_fire;

	// ----------------------------------------
	// Write channel
	// ----------------------------------------

	// No new address while one is held or a response waits
	assign S_AXI_AWREADY = (wr_state == ch_addr) && !aw_held;
	// Data only with a held address or one arriving on the same beat
	assign S_AXI_WREADY = (wr_state == ch_addr) && !running
		&& (aw_held || S_AXI_AWVALID);
	assign S_AXI_BVALID = (wr_state == ch_data);
	assign S_AXI_BRESP = resp_okay;

	assign aw_fire = S_AXI_AWVALID && S_AXI_AWREADY;
	assign w_fire = S_AXI_WVALID && S_AXI_WREADY;

	// Data beat always completes the write
	assign wr_commit = w_fire;
	// Held index, or the live one for a joint beat
	assign wr_idx = aw_held ? wr_idx_q : S_AXI_AWADDR[addr_lsb +: reg_idx_w];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_state <= ch_idle;
			aw_held <= 1'b0;
		end
		else
		begin
			case (wr_state)
				// Open the channel one cycle after reset
				ch_idle:
				begin
					wr_state <= ch_addr;
				end
				ch_addr:
				begin
					if (w_fire)
					begin
						wr_state <= ch_data;
						aw_held <= 1'b0;
					end
					else if (aw_fire)
					begin
						aw_held <= 1'b1;
					end
				end
				// Response pending, channel closed until BREADY
				ch_data:
				begin
					if (S_AXI_BREADY)
						wr_state <= ch_addr;
				end
				default:
				begin
					wr_state <= ch_idle;
				end
			endcase
		end
	end

	// Word index of an address that came ahead of its data
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_fire && !w_fire)
			wr_idx_q <= S_AXI_AWADDR[addr_lsb +: reg_idx_w];
	end

	// ----------------------------------------
	// Read channel
	// ----------------------------------------

	assign S_AXI_ARREADY = (rd_state == ch_addr);
	assign S_AXI_RVALID = (rd_state == ch_data);
	assign S_AXI_RRESP = resp_okay;

	assign ar_fire = S_AXI_ARVALID && S_AXI_ARREADY;
	// Read mux samples the address on this beat
	assign rd_capture = ar_fire;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_state <= ch_idle;
		else
		begin
			case (rd_state)
				ch_idle:
				begin
					rd_state <= ch_addr;
				end
				ch_addr:
				begin
					if (ar_fire)
						rd_state <= ch_data;
				end
				// ARREADY comes back the cycle after the data beat
				ch_data:
				begin
					if (S_AXI_RREADY)
						rd_state <= ch_addr;
				end
				default:
				begin
					rd_state <= ch_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/csr_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire rd_capture,
	input wire axi_lite_pkg::axi_addr_t S_AXI_ARADDR,
	// Register file contents
	input wire conv_csr_pkg::conv_param_t kernel_size,
	input wire conv_csr_pkg::conv_param_t stride,
	input wire conv_csr_pkg::conv_param_t padding,
	input wire has_bias,
	input wire has_relu,
	input wire conv_mode,
	input wire start,
	input wire conv_csr_pkg::csr_word_t kernel_baseaddr,
	input wire conv_csr_pkg::csr_word_t feature_baseaddr,
	input wire conv_csr_pkg::csr_word_t feature_width,
	input wire conv_csr_pkg::csr_word_t feature_height,
	input wire conv_csr_pkg::csr_word_t feature_chin,
	input wire conv_csr_pkg::csr_word_t feature_chout,
	input wire conv_csr_pkg::csr_word_t output_baseaddr,
	input wire conv_csr_pkg::csr_word_t output_width,
	input wire conv_csr_pkg::csr_word_t output_height,
	// Live engine status
	input wire running,
	input wire compute_done,
	input wire exception,
	output axi_lite_pkg::axi_data_t S_AXI_RDATA
);
	import axi_lite_pkg::*;
	import conv_csr_pkg::*;

	reg_idx_t rd_idx_q;
	csr_word_t ctrl_word;

	// Index held for the whole data phase
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_idx_q <= '0;
		else if (rd_capture)
			rd_idx_q <= S_AXI_ARADDR[addr_lsb +: reg_idx_w];
	end

	// ----------------------------------------
	// Control word with status merged in
	// ----------------------------------------

	always_comb
	begin
		// Reserved bit 4 stays zero
		ctrl_word = '0;
		ctrl_word[ctrl_start_bit] = start;
		ctrl_word[ctrl_exception_bit] = exception;
		ctrl_word[ctrl_done_bit] = compute_done;
		ctrl_word[ctrl_running_bit] = running;
		ctrl_word[ctrl_conv_mode_bit] = conv_mode;
		ctrl_word[ctrl_relu_bit] = has_relu;
		ctrl_word[ctrl_bias_bit] = has_bias;
		ctrl_word[ctrl_padding_lsb +: $bits(conv_param_t)] = padding;
		ctrl_word[ctrl_stride_lsb +: $bits(conv_param_t)] = stride;
		ctrl_word[ctrl_kernel_lsb +: $bits(conv_param_t)] = kernel_size;
	end

	// Read data follows register changes while RVALID waits
	always_comb
	begin
		case (rd_idx_q)
			reg_ctrl: S_AXI_RDATA = ctrl_word;
			reg_kernel_base: S_AXI_RDATA = kernel_baseaddr;
			reg_feature_base: S_AXI_RDATA = feature_baseaddr;
			reg_feature_width: S_AXI_RDATA = feature_width;
			reg_feature_height: S_AXI_RDATA = feature_height;
			reg_feature_chin: S_AXI_RDATA = feature_chin;
			reg_feature_chout: S_AXI_RDATA = feature_chout;
			reg_output_base: S_AXI_RDATA = output_baseaddr;
			reg_output_width: S_AXI_RDATA = output_width;
			reg_output_height: S_AXI_RDATA = output_height;
			// Unmapped words read zero
			default: S_AXI_RDATA = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/csr_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_reg_file (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Commit strobe and target from the channel controller
	input wire wr_commit,
	input wire conv_csr_pkg::reg_idx_t wr_idx,
	input wire axi_lite_pkg::axi_data_t S_AXI_WDATA,
	input wire axi_lite_pkg::axi_strb_t S_AXI_WSTRB,
	// Control word fields
	output conv_csr_pkg::conv_param_t kernel_size,
	output conv_csr_pkg::conv_param_t stride,
	output conv_csr_pkg::conv_param_t padding,
	output logic has_bias,
	output logic has_relu,
	output logic conv_mode,
	output logic start,
	// Wide registers
	output conv_csr_pkg::csr_word_t kernel_baseaddr,
	output conv_csr_pkg::csr_word_t feature_baseaddr,
	output conv_csr_pkg::csr_word_t feature_width,
	output conv_csr_pkg::csr_word_t feature_height,
	output conv_csr_pkg::csr_word_t feature_chin,
	output conv_csr_pkg::csr_word_t feature_chout,
	output conv_csr_pkg::csr_word_t output_baseaddr,
	output conv_csr_pkg::csr_word_t output_width,
	output conv_csr_pkg::csr_word_t output_height
);
	import axi_lite_pkg::*;
	import conv_csr_pkg::*;

	// Indexes 1 to 9, slot 0 is the control word
	csr_word_t wide_q [1:reg_count-1];
	logic ctrl_wr;

	assign ctrl_wr = wr_commit && (wr_idx == reg_ctrl);

	// ----------------------------------------
	// Control word
	// ----------------------------------------

	// Whole-word write, WSTRB ignored
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			kernel_size <= '0;
			stride <= '0;
			padding <= '0;
			has_bias <= 1'b0;
			has_relu <= 1'b0;
			conv_mode <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			// One-cycle pulse, low unless this edge commits bit 0
			start <= ctrl_wr && S_AXI_WDATA[ctrl_start_bit];
			if (ctrl_wr)
			begin
				conv_mode <= S_AXI_WDATA[ctrl_conv_mode_bit];
				has_relu <= S_AXI_WDATA[ctrl_relu_bit];
				has_bias <= S_AXI_WDATA[ctrl_bias_bit];
				padding <= S_AXI_WDATA[ctrl_padding_lsb +: $bits(conv_param_t)];
				stride <= S_AXI_WDATA[ctrl_stride_lsb +: $bits(conv_param_t)];
				kernel_size <= S_AXI_WDATA[ctrl_kernel_lsb +: $bits(conv_param_t)];
			end
		end
	end

	// ----------------------------------------
	// Wide registers
	// ----------------------------------------

	// Byte-strobe write into the addressed word
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int i = 1; i < reg_count; i++)
				wide_q[i] <= '0;
		end
		else if (wr_commit)
		begin
			for (int i = 1; i < reg_count; i++)
			begin
				if (wr_idx == reg_idx_t'(i))
				begin
					// Disabled lanes keep their old byte
					for (int b = 0; b < axi_strb_w; b++)
					begin
						if (S_AXI_WSTRB[b])
							wide_q[i][b*8 +: 8] <= S_AXI_WDATA[b*8 +: 8];
					end
				end
			end
		end
	end

	assign kernel_baseaddr = wide_q[reg_kernel_base];
	assign feature_baseaddr = wide_q[reg_feature_base];
	assign feature_width = wide_q[reg_feature_width];
	assign feature_height = wide_q[reg_feature_height];
	assign feature_chin = wide_q[reg_feature_chin];
	assign feature_chout = wide_q[reg_feature_chout];
	assign output_baseaddr = wide_q[reg_output_base];
	assign output_width = wide_q[reg_output_width];
	assign output_height = wide_q[reg_output_height];

endmodule

`default_nettype wire

/* test/tb_axi_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_csr;
	import axi_lite_pkg::*;
	import conv_csr_pkg::*;

	// ----------------------------------------
	// Test lengths and run limit
	// ----------------------------------------

	localparam int reset_cycles = 16;
	localparam int n_wide = 40;
	localparam int n_ctrl = 16;
	localparam int n_unmapped = 8;
	localparam int n_lock = 3;
	// Every loop step is one write and one read on top of sixteen reads after reset
	localparam int planned_txn = 16 + 2 * (n_wide + n_ctrl + n_unmapped + n_lock);
	localparam int cycle_limit = reset_cycles + 20 * planned_txn;

	// Starts low without an edge at time zero
	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN;
	axi_addr_t S_AXI_AWADDR;
	logic S_AXI_AWVALID;
	logic S_AXI_AWREADY;
	axi_data_t S_AXI_WDATA;
	axi_strb_t S_AXI_WSTRB;
	logic S_AXI_WVALID;
	logic S_AXI_WREADY;
	axi_resp_t S_AXI_BRESP;
	logic S_AXI_BVALID;
	logic S_AXI_BREADY;
	axi_addr_t S_AXI_ARADDR;
	logic S_AXI_ARVALID;
	logic S_AXI_ARREADY;
	axi_data_t S_AXI_RDATA;
	axi_resp_t S_AXI_RRESP;
	logic S_AXI_RVALID;
	logic S_AXI_RREADY;
	logic running;
	logic compute_done;
	logic exception;
	conv_param_t kernel_size;
	conv_param_t stride;
	conv_param_t padding;
	logic has_bias;
	logic has_relu;
	logic conv_mode;
	logic start;
	csr_word_t kernel_baseaddr;
	csr_word_t feature_baseaddr;
	csr_word_t feature_width;
	csr_word_t feature_height;
	csr_word_t feature_chin;
	csr_word_t feature_chout;
	csr_word_t output_baseaddr;
	csr_word_t output_width;
	csr_word_t output_height;

	// Register model where slot 0 holds only the configuration bits 31:5
	logic [31:0] model_q [0:9];
	logic [31:0] lfsr_q;
	logic [3:0] wr_target;
	logic start_due;
	logic b_held;
	logic r_held;
	int errors;
	int cycle_count;

	// Port names match the testbench signals one to one
	axi_csr_top uut (.*);

	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	// ----------------------------------------
	// Random source and helpers
	// ----------------------------------------

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Move to the next drive point 1 ns after the rising edge
	task automatic tick();
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic compare_word(input string what, input logic [31:0] exp,
		input logic [31:0] got);
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	// Control word applies whole while wide words merge enabled bytes
	task automatic model_write(input logic [3:0] idx, input logic [31:0] data,
		input logic [3:0] strb);
		if (idx == 4'd0)
			model_q[0] = data & 32'hFFFF_FFE0;
		else if (idx <= 4'd9)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (strb[b])
					model_q[idx][b*8 +: 8] = data[b*8 +: 8];
			end
		end
	endtask

	// Status inputs land at bits 3:1 and start has cleared by read time
	function automatic logic [31:0] expected_word(input logic [3:0] idx);
		if (idx == 4'd0)
			return model_q[0] | {28'b0, running, compute_done, exception, 1'b0};
		else if (idx <= 4'd9)
			return model_q[idx];
		return 32'b0;
	endfunction

	task automatic check_idle_outputs(input string when);
		if ({S_AXI_AWREADY, S_AXI_WREADY, S_AXI_ARREADY, S_AXI_BVALID,
			S_AXI_RVALID, start} !== 6'b0)
			report_error({"ready, valid or start output was high ", when});
	endtask

	task automatic check_ports();
		compare_word("kernel_size", 32'(model_q[0][31:24]), 32'(kernel_size));
		compare_word("stride", 32'(model_q[0][23:16]), 32'(stride));
		compare_word("padding", 32'(model_q[0][15:8]), 32'(padding));
		compare_word("has_bias", 32'(model_q[0][7]), 32'(has_bias));
		compare_word("has_relu", 32'(model_q[0][6]), 32'(has_relu));
		compare_word("conv_mode", 32'(model_q[0][5]), 32'(conv_mode));
		compare_word("kernel_baseaddr", model_q[1], kernel_baseaddr);
		compare_word("feature_baseaddr", model_q[2], feature_baseaddr);
		compare_word("feature_width", model_q[3], feature_width);
		compare_word("feature_height", model_q[4], feature_height);
		compare_word("feature_chin", model_q[5], feature_chin);
		compare_word("feature_chout", model_q[6], feature_chout);
		compare_word("output_baseaddr", model_q[7], output_baseaddr);
		compare_word("output_width", model_q[8], output_width);
		compare_word("output_height", model_q[9], output_height);
	endtask

	// ----------------------------------------
	// Bus tasks
	// ----------------------------------------

	// Order 0 is a joint beat, 1 puts the address first and 2 the data first
	task automatic write_reg(input logic [3:0] idx, input logic [31:0] data,
		input logic [3:0] strb);
		int order;
		int aw_wait;
		int w_wait;
		int b_wait;
		bit aw_done;
		bit w_done;
		bit b_done;
		bit first;
		order = next_bits(2) % 3;
		aw_wait = 0;
		w_wait = 0;
		if (order == 1)
			w_wait = 1 + next_bits(2);
		if (order == 2)
			aw_wait = 1 + next_bits(2);
		b_wait = next_bits(2);
		wr_target = idx;
		S_AXI_AWADDR = {idx, 2'b00};
		S_AXI_WDATA = data;
		S_AXI_WSTRB = strb;
		aw_done = 0;
		w_done = 0;
		while (!(aw_done && w_done))
		begin
			S_AXI_AWVALID = !aw_done && (aw_wait == 0);
			S_AXI_WVALID = !w_done && (w_wait == 0);
			@(negedge S_AXI_ACLK);
			if (S_AXI_AWVALID && S_AXI_AWREADY)
				aw_done = 1;
			if (S_AXI_WVALID && S_AXI_WREADY)
				w_done = 1;
			if (aw_wait > 0)
				aw_wait--;
			if (w_wait > 0)
				w_wait--;
			tick();
		end
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID = 1'b0;
		// Response phase with a random BREADY stall
		b_done = 0;
		first = 1;
		while (!b_done)
		begin
			S_AXI_BREADY = (b_wait == 0);
			@(negedge S_AXI_ACLK);
			if (first && !S_AXI_BVALID)
				report_error("BVALID did not rise one cycle after the write was accepted");
			first = 0;
			if (S_AXI_BVALID && S_AXI_BREADY)
				b_done = 1;
			if (b_wait > 0)
				b_wait--;
			tick();
		end
		S_AXI_BREADY = 1'b0;
		model_write(idx, data, strb);
	endtask

	task automatic read_reg(input logic [3:0] idx, output logic [31:0] data);
		int ar_wait;
		int r_wait;
		bit ar_done;
		bit r_done;
		bit first;
		ar_wait = next_bits(2) % 3;
		r_wait = next_bits(2);
		S_AXI_ARADDR = {idx, 2'b00};
		ar_done = 0;
		while (!ar_done)
		begin
			S_AXI_ARVALID = (ar_wait == 0);
			@(negedge S_AXI_ACLK);
			if (S_AXI_ARVALID && S_AXI_ARREADY)
				ar_done = 1;
			if (ar_wait > 0)
				ar_wait--;
			tick();
		end
		S_AXI_ARVALID = 1'b0;
		// Address must have been latched on its beat
		S_AXI_ARADDR = axi_addr_t'(next_bits(6));
		r_done = 0;
		first = 1;
		data = '0;
		while (!r_done)
		begin
			S_AXI_RREADY = (r_wait == 0);
			@(negedge S_AXI_ACLK);
			if (first && !S_AXI_RVALID)
				report_error("RVALID did not rise one cycle after the read address beat");
			first = 0;
			if (S_AXI_RVALID && S_AXI_RREADY)
			begin
				r_done = 1;
				data = S_AXI_RDATA;
			end
			if (r_wait > 0)
				r_wait--;
			tick();
		end
		S_AXI_RREADY = 1'b0;
	endtask

	task automatic check_read(input logic [3:0] idx);
		logic [31:0] got;
		logic [31:0] exp;
		read_reg(idx, got);
		exp = expected_word(idx);
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t: register %0d read expected %h got %h",
				$time, idx, exp, got);
		end
	endtask

	// Random status inputs for a control word read
	task automatic set_status();
		logic [2:0] s;
		s = 3'(next_bits(3));
		{running, compute_done, exception} = s;
	endtask

	// ----------------------------------------
	// Protocol monitor at the falling edge
	// ----------------------------------------

	always @(negedge S_AXI_ACLK)
	begin
		if (start !== start_due)
		begin
			errors++;
			$display("mismatch at %0t: start expected %0b got %0b", $time, start_due, start);
		end
		// A data beat on the control word with bit 0 set pulses start next cycle
		start_due = S_AXI_WVALID && S_AXI_WREADY && (wr_target == 4'd0) && S_AXI_WDATA[0];
		if (S_AXI_BVALID && (S_AXI_AWREADY || S_AXI_WREADY))
			report_error("write channel was ready while a response was pending");
		if (S_AXI_RVALID && S_AXI_ARREADY)
			report_error("ARREADY was high while read data was pending");
		if (running && S_AXI_WREADY)
			report_error("WREADY was high while the engine was running");
		if (S_AXI_BVALID && S_AXI_BRESP !== 2'b00)
			compare_word("BRESP", 32'd0, 32'(S_AXI_BRESP));
		if (S_AXI_RVALID && S_AXI_RRESP !== 2'b00)
			compare_word("RRESP", 32'd0, 32'(S_AXI_RRESP));
		if (b_held && !S_AXI_BVALID)
			report_error("BVALID dropped before BREADY took it");
		if (r_held && !S_AXI_RVALID)
			report_error("RVALID dropped before RREADY took it");
		b_held = S_AXI_BVALID && !S_AXI_BREADY;
		r_held = S_AXI_RVALID && !S_AXI_RREADY;
	end

	// Watchdog
	initial
	begin
		cycle_count = 0;
		while (cycle_count < cycle_limit)
		begin
			@(posedge S_AXI_ACLK);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles, error count %0d", cycle_count, errors);
		$display("Checks failed");
		$finish;
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------

	initial
	begin
		logic [3:0] idx;
		logic [31:0] data;
		logic [3:0] strb;
		int hold;
		S_AXI_ARESETN = 1'b0;
		S_AXI_AWADDR = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA = '0;
		S_AXI_WSTRB = '0;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b0;
		S_AXI_ARADDR = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY = 1'b0;
		running = 1'b0;
		compute_done = 1'b0;
		exception = 1'b0;
		lfsr_q = 32'd82848;
		wr_target = 4'hF;
		start_due = 1'b0;
		b_held = 1'b0;
		r_held = 1'b0;
		errors = 0;
		for (int i = 0; i < 10; i++)
			model_q[i] = '0;
		repeat (reset_cycles) @(posedge S_AXI_ACLK);
		#1;
		check_idle_outputs("during reset");
		S_AXI_ARESETN = 1'b1;
		@(negedge S_AXI_ACLK);
		check_idle_outputs("in the first cycle after reset");
		tick();
		@(negedge S_AXI_ACLK);
		if (!S_AXI_AWREADY || !S_AXI_ARREADY)
			report_error("AWREADY or ARREADY did not rise one cycle after reset");
		tick();

		// Everything reads zero and the control word only shows status
		for (int i = 0; i < 16; i++)
		begin
			if (i == 0)
				set_status();
			check_read(4'(i));
			running = 1'b0;
		end
		check_ports();

		// Byte-strobe writes to the wide registers
		for (int i = 0; i < n_wide; i++)
		begin
			idx = 4'd1 + 4'(next_bits(4) % 9);
			data = next_bits(32);
			strb = 4'(next_bits(4));
			write_reg(idx, data, strb);
			check_read(idx);
			check_ports();
		end

		// Control word writes with random strobes, which it ignores
		for (int i = 0; i < n_ctrl; i++)
		begin
			data = next_bits(32);
			strb = 4'(next_bits(4));
			write_reg(4'd0, data, strb);
			check_ports();
			set_status();
			check_read(4'd0);
			running = 1'b0;
		end

		// Unmapped words take writes silently and read zero
		for (int i = 0; i < n_unmapped; i++)
		begin
			idx = 4'd10 + 4'(next_bits(3) % 6);
			data = next_bits(32);
			strb = 4'(next_bits(4));
			write_reg(idx, data, strb);
			check_read(idx);
			check_ports();
		end

		// Writes held off by the running lockout
		for (int i = 0; i < n_lock; i++)
		begin
			idx = 4'd1 + 4'(next_bits(4) % 9);
			data = next_bits(32);
			strb = 4'(next_bits(4));
			hold = 4 + next_bits(2);
			running = 1'b1;
			fork
				write_reg(idx, data, strb);
				begin
					repeat (hold)
					begin
						@(negedge S_AXI_ACLK);
						if (S_AXI_BVALID)
							report_error("write completed while the engine was running");
						tick();
					end
					running = 1'b0;
				end
			join
			check_read(idx);
			check_ports();
		end

		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
